// File: bender.yml
package:
  name: gpu_draw

sources:
  - logic/gpu_pkg.sv
  - logic/cmd_fifo.sv
  - logic/cmd_decoder.sv
  - logic/line_raster.sv
  - logic/clear_engine.sv
  - logic/sdram_arbiter.sv
  - logic/gpu_top.sv
  - target: simulation
    files:
      - sim/tb_gpu.sv

// File: logic/clear_engine.sv
`default_nettype none

module clear_engine #(
	parameter int FB_WIDTH  = gpu_pkg::FB_WIDTH_DEF,
	parameter int FB_HEIGHT = gpu_pkg::FB_HEIGHT_DEF
) (
	input  wire              clk,
	input  wire              rst_n,
	input  wire              clr_start,
	input  wire [7:0]        clr_colour,
	output logic             clr_busy,
	output logic             req,
	output gpu_pkg::pix_wr_t wr,
	input  wire              wait_req
);

	localparam int AW       = gpu_pkg::SD_ADDR_W;
	localparam int LAST_PIX = FB_WIDTH * FB_HEIGHT - 1;

	logic [AW-1:0] addr;
	logic [7:0]    colour;
	logic          done_wr;

	assign req     = clr_busy;
	assign done_wr = clr_busy && !wait_req;
	assign wr.addr = addr;
	assign wr.data = {24'h0, colour};

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			clr_busy <= 1'b0;
			addr     <= '0;
		end
		else if (clr_start && !clr_busy)
		begin
			clr_busy <= 1'b1;
			addr     <= '0;
		end
		else if (done_wr)
		begin
			// Sweep ends after the last pixel is written
			if (addr == AW'(LAST_PIX))
				clr_busy <= 1'b0;
			else
				addr <= addr + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (clr_start && !clr_busy)
			colour <= clr_colour;
	end

	a_start_idle: assert property (@(posedge clk) disable iff (!rst_n) clr_start |-> !clr_busy)
		else $error("clear started while a clear is running");

endmodule

`default_nettype wire

// File: logic/cmd_decoder.sv
`default_nettype none

module cmd_decoder (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire gpu_pkg::cmd_word_t cmd,
	input  wire                     empty,
	output logic                    pop,
	output logic                    line_valid,
	output gpu_pkg::line_req_t      line_req,
	input  wire                     line_ready,
	output logic                    clr_start,
	output logic [7:0]              clr_colour,
	input  wire                     clr_busy,
	output logic                    idle
);

	gpu_pkg::dec_state_e state;
	gpu_pkg::point_t     first_pt;
	gpu_pkg::point_t     prev_pt;
	gpu_pkg::point_t     cmd_pt;
	logic [7:0]          colour;
	logic                fetching;
	logic                cmd_ok;

	assign cmd_pt = {cmd.x, cmd.y};

	// States that may take a new word
	assign fetching = (state == gpu_pkg::DEC_IDLE) || (state == gpu_pkg::DEC_FIRST) ||
		(state == gpu_pkg::DEC_FETCH);

	// Keep ordering with work already handed to the peers
	always_comb
	begin
		case (cmd.op)
			gpu_pkg::BEGIN:  cmd_ok = line_ready && !clr_busy;
			gpu_pkg::VERTEX: cmd_ok = !clr_busy;
			gpu_pkg::END:    cmd_ok = !clr_busy;
			default:         cmd_ok = 1'b1;
		endcase
	end

	assign pop        = fetching && !empty && cmd_ok;
	assign line_valid = (state == gpu_pkg::DEC_DRAW) || (state == gpu_pkg::DEC_CLOSE);
	assign clr_start  = (state == gpu_pkg::DEC_CLEAR_WAIT) && line_ready && !clr_busy;
	assign idle       = fetching;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= gpu_pkg::DEC_IDLE;
		else if (pop)
		begin
			case (cmd.op)
				gpu_pkg::BEGIN:
					state <= gpu_pkg::DEC_FIRST;
				gpu_pkg::VERTEX:
				begin
					// A vertex outside a polyline is dropped
					if (state == gpu_pkg::DEC_FIRST)
						state <= gpu_pkg::DEC_FETCH;
					else if (state == gpu_pkg::DEC_FETCH)
						state <= gpu_pkg::DEC_DRAW;
				end
				gpu_pkg::END:
				begin
					if (state == gpu_pkg::DEC_FETCH)
						state <= gpu_pkg::DEC_CLOSE;
					else
						state <= gpu_pkg::DEC_IDLE;
				end
				gpu_pkg::CLEAR:
					state <= gpu_pkg::DEC_CLEAR_WAIT;
				default:
					state <= state;
			endcase
		end
		else if (state == gpu_pkg::DEC_DRAW && line_ready)
			state <= gpu_pkg::DEC_FETCH;
		else if (state == gpu_pkg::DEC_CLOSE && line_ready)
			state <= gpu_pkg::DEC_IDLE;
		else if (clr_start)
			state <= gpu_pkg::DEC_IDLE;
	end

	always_ff @(posedge clk)
	begin
		if (pop)
		begin
			case (cmd.op)
				gpu_pkg::BEGIN:
					colour <= cmd.y[7:0];
				gpu_pkg::CLEAR:
					clr_colour <= cmd.y[7:0];
				gpu_pkg::VERTEX:
				begin
					if (state == gpu_pkg::DEC_FIRST)
						first_pt <= cmd_pt;
					line_req <= {prev_pt, cmd_pt, colour};
					prev_pt  <= cmd_pt;
				end
				gpu_pkg::END:
					line_req <= {prev_pt, first_pt, colour};
				default:
					;
			endcase
		end
	end

	// Clear engine must report busy right after a start
	a_clr_taken: assert property (@(posedge clk) disable iff (!rst_n) clr_start |=> clr_busy)
		else $error("clear start not taken by clear engine");

endmodule

`default_nettype wire

// File: logic/cmd_fifo.sv
`default_nettype none

module cmd_fifo #(
	parameter int FIFO_DEPTH = gpu_pkg::FIFO_DEPTH_DEF
) (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     wr_en,
	input  wire gpu_pkg::cmd_word_t wr_data,
	input  wire                     pop,
	output gpu_pkg::cmd_word_t      rd_data,
	output logic                    empty,
	output logic                    full
);

	localparam int PW = $clog2(FIFO_DEPTH);
	localparam int CW = $clog2(FIFO_DEPTH + 1);

	gpu_pkg::cmd_word_t mem [FIFO_DEPTH];
	logic [PW-1:0]      wr_ptr;
	logic [PW-1:0]      rd_ptr;
	logic [CW-1:0]      count;
	logic               push;
	logic               take;

	function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
		return (p == PW'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign push    = wr_en && !full;
	assign take    = pop && !empty;
	assign empty   = (count == '0);
	assign full    = (count == CW'(FIFO_DEPTH));
	// Show-ahead read
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (take)
				rd_ptr <= next_ptr(rd_ptr);
			if (push && !take)
				count <= count + 1'b1;
			else if (take && !push)
				count <= count - 1'b1;
		end
	end

	// Host must respect full and the decoder must respect empty
	a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> !full)
		else $error("command word written while FIFO full");
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty)
		else $error("pop from empty command FIFO");

endmodule

`default_nettype wire

// File: logic/gpu_pkg.sv
`default_nettype none

package gpu_pkg;

	localparam int SD_ADDR_W = 22;

	// Default framebuffer geometry and queue size for gpu_top
	localparam int FB_WIDTH_DEF   = 64;
	localparam int FB_HEIGHT_DEF  = 48;
	localparam int FIFO_DEPTH_DEF = 16;

	typedef enum logic [3:0] {
		VERTEX = 4'h0,
		BEGIN  = 4'h1,
		END    = 4'h2,
		CLEAR  = 4'h3
	} gpu_opcode_e;

	// Host command word
	// BEGIN and CLEAR carry their colour in the low byte of y
	typedef struct packed {
		gpu_opcode_e op;
		logic [11:0] x;
		logic [3:0]  pad;
		logic [11:0] y;
	} cmd_word_t;

	typedef struct packed {
		logic [11:0] x;
		logic [11:0] y;
	} point_t;

	typedef struct packed {
		point_t     p0;
		point_t     p1;
		logic [7:0] colour;
	} line_req_t;

	typedef struct packed {
		logic [SD_ADDR_W-1:0] addr;
		logic [31:0]          data;
	} pix_wr_t;

	typedef enum logic [2:0] {
		DEC_IDLE,
		DEC_FETCH,
		DEC_FIRST,
		DEC_DRAW,
		DEC_CLOSE,
		DEC_CLEAR_WAIT
	} dec_state_e;

	typedef enum logic [1:0] {
		RS_IDLE,
		RS_SETUP,
		RS_STEP
	} raster_state_e;

endpackage

`default_nettype wire

// File: logic/gpu_top.sv
`default_nettype none

module gpu_top #(
	parameter int FB_WIDTH   = gpu_pkg::FB_WIDTH_DEF,
	parameter int FB_HEIGHT  = gpu_pkg::FB_HEIGHT_DEF,
	parameter int FIFO_DEPTH = gpu_pkg::FIFO_DEPTH_DEF
) (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire gpu_pkg::cmd_word_t      fifo_write_data,
	input  wire                          fifo_write,
	output logic                         fifo_full,
	input  wire                          sd_waitrequest,
	output logic                         sd_write,
	output logic [31:0]                  sd_wdata,
	output logic [gpu_pkg::SD_ADDR_W-1:0] sd_address,
	output logic                         busy
);

	gpu_pkg::cmd_word_t     cmd;
	gpu_pkg::line_req_t     line_req;
	gpu_pkg::pix_wr_t [1:0] pix_wr;
	logic [1:0]             pix_req;
	logic [1:0]             pix_wait;
	logic [7:0]             clr_colour;
	logic                   fifo_empty;
	logic                   pop;
	logic                   line_valid;
	logic                   line_ready;
	logic                   clr_start;
	logic                   clr_busy;
	logic                   dec_idle;

	cmd_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
		.clk     (clk),
		.rst_n   (rst_n),
		.wr_en   (fifo_write),
		.wr_data (fifo_write_data),
		.pop     (pop),
		.rd_data (cmd),
		.empty   (fifo_empty),
		.full    (fifo_full)
	);

	cmd_decoder u_dec (
		.clk        (clk),
		.rst_n      (rst_n),
		.cmd        (cmd),
		.empty      (fifo_empty),
		.pop        (pop),
		.line_valid (line_valid),
		.line_req   (line_req),
		.line_ready (line_ready),
		.clr_start  (clr_start),
		.clr_colour (clr_colour),
		.clr_busy   (clr_busy),
		.idle       (dec_idle)
	);

	// Port 0 is the rasterizer and port 1 the clear engine
	line_raster #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) u_raster (
		.clk        (clk),
		.rst_n      (rst_n),
		.line_valid (line_valid),
		.line_req   (line_req),
		.line_ready (line_ready),
		.req        (pix_req[0]),
		.wr         (pix_wr[0]),
		.wait_req   (pix_wait[0])
	);

	clear_engine #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) u_clear (
		.clk        (clk),
		.rst_n      (rst_n),
		.clr_start  (clr_start),
		.clr_colour (clr_colour),
		.clr_busy   (clr_busy),
		.req        (pix_req[1]),
		.wr         (pix_wr[1]),
		.wait_req   (pix_wait[1])
	);

	sdram_arbiter u_arb (
		.clk            (clk),
		.rst_n          (rst_n),
		.req            (pix_req),
		.wr             (pix_wr),
		.wait_req       (pix_wait),
		.sd_write       (sd_write),
		.sd_address     (sd_address),
		.sd_wdata       (sd_wdata),
		.sd_waitrequest (sd_waitrequest)
	);

	// Work queued or in flight anywhere
	assign busy = !fifo_empty || !dec_idle || !line_ready || clr_busy;

endmodule

`default_nettype wire

// File: logic/line_raster.sv
`default_nettype none

module line_raster #(
	parameter int FB_WIDTH  = gpu_pkg::FB_WIDTH_DEF,
	parameter int FB_HEIGHT = gpu_pkg::FB_HEIGHT_DEF
) (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     line_valid,
	input  wire gpu_pkg::line_req_t line_req,
	output logic                    line_ready,
	output logic                    req,
	output gpu_pkg::pix_wr_t        wr,
	input  wire                     wait_req
);

	localparam int AW = gpu_pkg::SD_ADDR_W;

	gpu_pkg::raster_state_e state;
	gpu_pkg::line_req_t     job;
	logic [11:0]            cur_x;
	logic [11:0]            cur_y;
	logic                   sx_neg;
	logic                   sy_neg;
	logic signed [12:0]     ddx;
	logic signed [12:0]     ddy;
	logic signed [13:0]     adx;
	logic signed [13:0]     ady;
	logic signed [13:0]     dx;
	logic signed [13:0]     dy;
	logic signed [14:0]     err;
	logic signed [14:0]     err_nxt;
	logic signed [15:0]     e2;
	logic                   done_wr;
	logic                   at_end;

	assign line_ready = (state == gpu_pkg::RS_IDLE);
	assign req        = (state == gpu_pkg::RS_STEP);
	assign done_wr    = req && !wait_req;
	assign at_end     = (cur_x == job.p1.x) && (cur_y == job.p1.y);

	assign wr.addr = AW'(cur_y * FB_WIDTH + cur_x);
	assign wr.data = {24'h0, job.colour};

	// Absolute distances for setup
	assign ddx = $signed({1'b0, job.p1.x}) - $signed({1'b0, job.p0.x});
	assign ddy = $signed({1'b0, job.p1.y}) - $signed({1'b0, job.p0.y});
	assign adx = (ddx < 0) ? -ddx : ddx;
	assign ady = (ddy < 0) ? -ddy : ddy;

	// dy is kept negative so one error term covers every octant
	assign e2 = {err, 1'b0};

	always_comb
	begin
		err_nxt = err;
		if (e2 >= dy)
			err_nxt = err_nxt + dy;
		if (e2 <= dx)
			err_nxt = err_nxt + dx;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= gpu_pkg::RS_IDLE;
		else
		begin
			case (state)
				gpu_pkg::RS_IDLE:
					if (line_valid)
						state <= gpu_pkg::RS_SETUP;
				gpu_pkg::RS_SETUP:
					state <= gpu_pkg::RS_STEP;
				gpu_pkg::RS_STEP:
					if (done_wr && at_end)
						state <= gpu_pkg::RS_IDLE;
				default:
					state <= gpu_pkg::RS_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (line_valid && line_ready)
			job <= line_req;
		if (state == gpu_pkg::RS_SETUP)
		begin
			cur_x  <= job.p0.x;
			cur_y  <= job.p0.y;
			sx_neg <= (ddx < 0);
			sy_neg <= (ddy < 0);
			dx     <= adx;
			dy     <= -ady;
			err    <= adx - ady;
		end
		else if (done_wr && !at_end)
		begin
			err <= err_nxt;
			if (e2 >= dy)
				cur_x <= sx_neg ? cur_x - 12'd1 : cur_x + 12'd1;
			if (e2 <= dx)
				cur_y <= sy_neg ? cur_y - 12'd1 : cur_y + 12'd1;
		end
	end

	// Vertices from the host must stay inside the framebuffer
	a_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
		req |-> (int'(wr.addr) < FB_WIDTH * FB_HEIGHT))
		else $error("line pixel address outside framebuffer");

endmodule

`default_nettype wire

// File: logic/sdram_arbiter.sv
`default_nettype none

module sdram_arbiter (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire [1:0]                   req,
	input  wire gpu_pkg::pix_wr_t [1:0] wr,
	output logic [1:0]                  wait_req,
	output logic                        sd_write,
	output logic [gpu_pkg::SD_ADDR_W-1:0] sd_address,
	output logic [31:0]                 sd_wdata,
	input  wire                         sd_waitrequest
);

	logic [1:0] grant_q;
	logic [1:0] grant_n;
	logic       last_q;

	// Holder keeps the port until its request drops
	always_comb
	begin
		if (|(grant_q & req))
			grant_n = grant_q;
		else if (req == 2'b11)
			grant_n = last_q ? 2'b01 : 2'b10;
		else
			grant_n = req;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			grant_q <= 2'b00;
			last_q  <= 1'b0;
		end
		else
		begin
			grant_q <= grant_n;
			if (sd_write && !sd_waitrequest)
				last_q <= grant_q[1];
		end
	end

	assign sd_write   = |(grant_q & req);
	assign sd_address = grant_q[1] ? wr[1].addr : wr[0].addr;
	assign sd_wdata   = grant_q[1] ? wr[1].data : wr[0].data;
	assign wait_req   = ~grant_q | {2{sd_waitrequest}};

	a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant_q))
		else $error("more than one SDRAM grant");
	a_grant_stall: assert property (@(posedge clk) disable iff (!rst_n)
		(sd_write && sd_waitrequest) |=> $stable(grant_q))
		else $error("grant moved during a stalled write");

endmodule

`default_nettype wire

// File: sim/tb_gpu.sv
`default_nettype none

module tb_gpu;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int FB_W      = 64;
	localparam int FB_H      = 48;
	localparam int FIFO_D    = 16;
	localparam int FB_PIX    = FB_W * FB_H;
	localparam int NUM_TESTS = 5;
	localparam int MAX_CMDS  = 32;

	logic                              clk;
	logic                              rst_n;
	gpu_pkg::cmd_word_t                fifo_write_data;
	logic                              fifo_write;
	logic                              fifo_full;
	logic                              sd_waitrequest;
	logic                              sd_write;
	logic [31:0]                       sd_wdata;
	logic [gpu_pkg::SD_ADDR_W-1:0]     sd_address;
	logic                              busy;

	// Stimulus table
	string              test_name [NUM_TESTS];
	gpu_pkg::cmd_word_t test_cmd  [NUM_TESTS][MAX_CMDS];
	int                 test_len  [NUM_TESTS];
	logic               test_hold [NUM_TESTS];

	logic [31:0] sd_mem   [FB_PIX];
	logic [31:0] model_fb [FB_PIX];
	int          model_count;
	int          write_count;
	int          mismatches;
	int          other_errors;
	int          cycles;
	int          cycle_limit;
	int          total_pixels;
	logic [31:0] rng;
	logic        hold_wait;
	logic        wait_now;
	logic        saw_full;

	gpu_top #(
		.FB_WIDTH   (FB_W),
		.FB_HEIGHT  (FB_H),
		.FIFO_DEPTH (FIFO_D)
	) dut_i (
		.clk             (clk),
		.rst_n           (rst_n),
		.fifo_write_data (fifo_write_data),
		.fifo_write      (fifo_write),
		.fifo_full       (fifo_full),
		.sd_waitrequest  (sd_waitrequest),
		.sd_write        (sd_write),
		.sd_wdata        (sd_wdata),
		.sd_address      (sd_address),
		.busy            (busy)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32();
		logic [31:0] x;
		x = rng;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng = x;
		return x;
	endfunction

	function automatic gpu_pkg::cmd_word_t make_clear(input logic [7:0] colour);
		gpu_pkg::cmd_word_t c;
		c = '0;
		c.op = gpu_pkg::CLEAR;
		c.y = {4'h0, colour};
		return c;
	endfunction

	function automatic gpu_pkg::cmd_word_t make_begin(input logic [7:0] colour);
		gpu_pkg::cmd_word_t c;
		c = '0;
		c.op = gpu_pkg::BEGIN;
		c.y = {4'h0, colour};
		return c;
	endfunction

	function automatic gpu_pkg::cmd_word_t make_vertex(input int x, input int y);
		gpu_pkg::cmd_word_t c;
		c = '0;
		c.op = gpu_pkg::VERTEX;
		c.x = 12'(x);
		c.y = 12'(y);
		return c;
	endfunction

	function automatic gpu_pkg::cmd_word_t make_end();
		gpu_pkg::cmd_word_t c;
		c = '0;
		c.op = gpu_pkg::END;
		return c;
	endfunction

	task automatic add_word(input int t, input gpu_pkg::cmd_word_t w);
		test_cmd[t][test_len[t]] = w;
		test_len[t]++;
	endtask

	task automatic build_table();
		for (int t = 0; t < NUM_TESTS; t++)
		begin
			test_len[t] = 0;
			test_hold[t] = 1'b0;
		end
		test_name[0] = "clear_only";
		add_word(0, make_clear(8'h11));

		test_name[1] = "triangle";
		add_word(1, make_clear(8'h22));
		add_word(1, make_begin(8'h5a));
		add_word(1, make_vertex(20, 10));
		add_word(1, make_vertex(30, 10));
		add_word(1, make_vertex(20, 20));
		add_word(1, make_end());

		// Star around the centre, every spoke drawn out and back
		test_name[2] = "octants";
		add_word(2, make_clear(8'h33));
		add_word(2, make_begin(8'h7c));
		add_word(2, make_vertex(32, 24));
		add_word(2, make_vertex(45, 28));
		add_word(2, make_vertex(32, 24));
		add_word(2, make_vertex(35, 40));
		add_word(2, make_vertex(32, 24));
		add_word(2, make_vertex(20, 29));
		add_word(2, make_vertex(32, 24));
		add_word(2, make_vertex(28, 5));
		add_word(2, make_vertex(32, 24));
		add_word(2, make_vertex(10, 20));
		add_word(2, make_vertex(32, 24));
		add_word(2, make_vertex(40, 3));
		add_word(2, make_vertex(32, 24));
		add_word(2, make_vertex(50, 24));
		add_word(2, make_vertex(32, 24));
		add_word(2, make_vertex(32, 45));
		add_word(2, make_end());
		add_word(2, make_begin(8'h44));
		add_word(2, make_vertex(5, 5));
		add_word(2, make_end());
		add_word(2, make_begin(8'h45));
		add_word(2, make_vertex(60, 40));
		add_word(2, make_vertex(60, 40));
		add_word(2, make_end());

		test_name[3] = "random_wait";
		add_word(3, make_clear(8'h01));
		add_word(3, make_begin(8'h90));
		add_word(3, make_vertex(2, 2));
		add_word(3, make_vertex(61, 45));
		add_word(3, make_vertex(61, 2));
		add_word(3, make_vertex(2, 45));
		add_word(3, make_end());
		add_word(3, make_begin(8'ha5));
		add_word(3, make_vertex(0, 47));
		add_word(3, make_vertex(63, 0));
		add_word(3, make_end());

		// Zigzag long enough to overrun the FIFO
		test_name[4] = "fifo_full";
		test_hold[4] = 1'b1;
		add_word(4, make_clear(8'h0f));
		add_word(4, make_begin(8'hc3));
		for (int i = 0; i < 20; i++)
			add_word(4, make_vertex(3 + 2 * i, (i % 2) ? 40 : 8));
		add_word(4, make_end());
	endtask

	// Integer Bresenham, both endpoints included
	task automatic model_line(input int x0, input int y0, input int x1, input int y1,
		input logic [7:0] colour);
		int   dx;
		int   dy;
		int   sx;
		int   sy;
		int   err;
		int   e2;
		int   x;
		int   y;
		logic done;
		dx = (x1 > x0) ? x1 - x0 : x0 - x1;
		dy = (y1 > y0) ? y0 - y1 : y1 - y0;
		sx = (x0 < x1) ? 1 : -1;
		sy = (y0 < y1) ? 1 : -1;
		err = dx + dy;
		x = x0;
		y = y0;
		done = 1'b0;
		while (!done)
		begin
			model_fb[y * FB_W + x] = {24'h0, colour};
			model_count++;
			if (x == x1 && y == y1)
				done = 1'b1;
			else
			begin
				e2 = 2 * err;
				if (e2 >= dy)
				begin
					err = err + dy;
					x = x + sx;
				end
				if (e2 <= dx)
				begin
					err = err + dx;
					y = y + sy;
				end
			end
		end
	endtask

	task automatic run_model(input int t);
		gpu_pkg::cmd_word_t c;
		logic [7:0]         colour;
		logic               in_poly;
		int                 nv;
		int                 fx;
		int                 fy;
		int                 px;
		int                 py;
		model_count = 0;
		colour = 8'h0;
		in_poly = 1'b0;
		nv = 0;
		fx = 0;
		fy = 0;
		px = 0;
		py = 0;
		for (int i = 0; i < test_len[t]; i++)
		begin
			c = test_cmd[t][i];
			case (c.op)
				gpu_pkg::CLEAR:
				begin
					for (int a = 0; a < FB_PIX; a++)
						model_fb[a] = {24'h0, c.y[7:0]};
					model_count += FB_PIX;
				end
				gpu_pkg::BEGIN:
				begin
					colour = c.y[7:0];
					in_poly = 1'b1;
					nv = 0;
				end
				gpu_pkg::VERTEX:
				begin
					if (in_poly)
					begin
						if (nv == 0)
						begin
							fx = int'(c.x);
							fy = int'(c.y);
						end
						else
							model_line(px, py, int'(c.x), int'(c.y), colour);
						px = int'(c.x);
						py = int'(c.y);
						nv++;
					end
				end
				gpu_pkg::END:
				begin
					if (in_poly && nv > 0)
						model_line(px, py, fx, fy, colour);
					in_poly = 1'b0;
				end
				default:
					;
			endcase
		end
	endtask

	task automatic check_pixel(input string name, input logic [gpu_pkg::SD_ADDR_W-1:0] addr,
		input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected)
		begin
			mismatches++;
			$display("mismatch %s pixel %0d: expected %h, actual %h", name, addr, expected,
				actual);
		end
	endtask

	task automatic check_addr(input string name, input gpu_pkg::pix_wr_t wr);
		if (int'(wr.addr) >= FB_PIX)
		begin
			other_errors++;
			$display("%s: SDRAM write to address %0d lies outside the framebuffer", name,
				wr.addr);
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual != expected)
		begin
			mismatches++;
			$display("mismatch %s write count: expected %0d, actual %0d", name, expected,
				actual);
		end
	endtask

	// SDRAM model with random back-pressure
	always @(negedge clk)
	begin
		if (hold_wait)
			wait_now = 1'b1;
		else
			wait_now = (xorshift32() % 3 == 0);
		sd_waitrequest = wait_now;
		// Address and data are stable until the coming rising edge
		if (sd_write === 1'b1 && !wait_now)
		begin
			check_addr("sdram", {sd_address, sd_wdata});
			if (int'(sd_address) < FB_PIX)
				sd_mem[int'(sd_address)] = sd_wdata;
			write_count++;
		end
	end

	initial
	begin
		wait (cycle_limit > 0);
		while (cycles < cycle_limit)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run did not finish within %0d cycles", cycle_limit);
		$display("ERRORS FOUND");
		$finish;
	end

	task automatic run_test(input int t);
		run_model(t);
		@(posedge clk);
		write_count = 0;
		saw_full = 1'b0;
		hold_wait = test_hold[t];
		for (int i = 0; i < test_len[t]; i++)
		begin
			@(negedge clk);
			while (fifo_full)
			begin
				saw_full = 1'b1;
				fifo_write = 1'b0;
				@(posedge clk);
				hold_wait = 1'b0;
				@(negedge clk);
			end
			fifo_write = 1'b1;
			fifo_write_data = test_cmd[t][i];
		end
		@(negedge clk);
		fifo_write = 1'b0;
		@(posedge clk);
		hold_wait = 1'b0;
		@(negedge clk);
		while (busy)
			@(negedge clk);
		if (test_hold[t] && !saw_full)
		begin
			other_errors++;
			$display("%s: fifo_full never went high while waitrequest was held", test_name[t]);
		end
		check_count(test_name[t], model_count, write_count);
		// Nothing may be written once busy has fallen
		repeat (8) @(negedge clk);
		check_count({test_name[t], " after idle"}, model_count, write_count);
		if (busy)
		begin
			other_errors++;
			$display("%s: busy rose again with no new commands", test_name[t]);
		end
		for (int a = 0; a < FB_PIX; a++)
			check_pixel(test_name[t], gpu_pkg::SD_ADDR_W'(a), model_fb[a], sd_mem[a]);
	endtask

	initial
	begin
		rst_n = 1'b0;
		fifo_write = 1'b0;
		fifo_write_data = '0;
		sd_waitrequest = 1'b0;
		rng = 32'd5137;
		hold_wait = 1'b0;
		wait_now = 1'b0;
		saw_full = 1'b0;
		mismatches = 0;
		other_errors = 0;
		write_count = 0;
		cycles = 0;
		cycle_limit = 0;
		for (int a = 0; a < FB_PIX; a++)
			sd_mem[a] = 32'hdead0000 ^ a;
		build_table();
		total_pixels = 0;
		for (int t = 0; t < NUM_TESTS; t++)
		begin
			run_model(t);
			total_pixels += model_count;
		end
		cycle_limit = total_pixels * 4 + 200;

		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		if (sd_write !== 1'b0 || busy !== 1'b0 || fifo_full !== 1'b0)
		begin
			other_errors++;
			$display("sd_write, busy or fifo_full is not low after reset");
		end

		for (int t = 0; t < NUM_TESTS; t++)
			run_test(t);

		$display("mismatches: %0d, other errors: %0d", mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
logic/gpu_pkg.sv
logic/cmd_fifo.sv
logic/cmd_decoder.sv
logic/line_raster.sv
logic/clear_engine.sv
logic/sdram_arbiter.sv
logic/gpu_top.sv
sim/tb_gpu.sv
